// ==== files.f ====
source/snoop_pkg.sv
source/snoop_ac_if.sv
source/snoop_arbiter.sv
source/snoop_idx_fifo.sv
source/cd_beat_counter.sv
source/snoop_port.sv
source/snoop_subsystem_top.sv
verification/tb_snoop_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_snoop_subsystem
RTL_TOP   ?= snoop_subsystem_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the search fails the target when the line is missing
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_snoop_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_snoop_subsystem import snoop_pkg::*; ();

    localparam int NUM_SNOOPS = 300;
    localparam int RR_GRANTS  = 40;
    // Budget per snoop grows with the snoops that may wait at the cache
    localparam int MAX_CYCLES = NUM_SNOOPS * 20 * IDX_FIFO_DEPTH;

    // Cache responder states
    localparam int C_IDLE = 0;
    localparam int C_WAIT = 1;
    localparam int C_CR   = 2;
    localparam int C_CD   = 3;

    logic clk;
    logic arst_n;

    logic   [NUM_INP-1:0] inp_ac_valid;
    logic   [NUM_INP-1:0] inp_ac_ready;
    addr_t  [NUM_INP-1:0] inp_ac_addr;
    snoop_t [NUM_INP-1:0] inp_ac_snoop;
    logic   [NUM_INP-1:0] inp_cr_valids;
    logic   [NUM_INP-1:0] inp_cr_readies;
    logic   [NUM_INP-1:0] inp_cd_valids;
    logic   [NUM_INP-1:0] inp_cd_readies;
    cr_resp_t             inp_cr_resp;
    cd_data_t             inp_cd_data;
    logic                 inp_cd_last;

    logic     oup_ac_valid;
    logic     oup_ac_ready;
    addr_t    oup_ac_addr;
    snoop_t   oup_ac_snoop;
    logic     oup_cr_valid;
    logic     oup_cr_ready;
    cr_resp_t oup_cr_resp;
    logic     oup_cd_valid;
    logic     oup_cd_ready;
    cd_data_t oup_cd_data;

    logic [31:0] seed;
    int value_errors;
    int proto_errors;
    int cycles;
    int issued;
    int cr_count;
    int grants;
    int last_grant;
    bit rr_check;

    // Requester side of the reference model
    bit [NUM_INP-1:0] pending;
    bit [NUM_INP-1:0] forwarded;
    bit               fwd_open;
    addr_t            fwd_addr;

    // Owners of outstanding snoops and of pending CD bursts in arrival order
    inp_idx_t own_idx_q[$];
    addr_t    own_addr_q[$];
    inp_idx_t cd_idx_q[$];
    addr_t    cd_addr_q[$];
    int       cd_beat;

    // Cache responder
    addr_t cache_q[$];
    int    cache_state;
    int    cache_delay;
    int    cache_beat;
    addr_t cache_addr;
    bit    cr_fired;
    bit    cd_fired;

    snoop_subsystem_top dut0 (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .inp_ac_valid_i   (inp_ac_valid),
        .inp_ac_ready_o   (inp_ac_ready),
        .inp_ac_addr_i    (inp_ac_addr),
        .inp_ac_snoop_i   (inp_ac_snoop),
        .inp_cr_valids_o  (inp_cr_valids),
        .inp_cr_readies_i (inp_cr_readies),
        .inp_cr_resp_o    (inp_cr_resp),
        .inp_cd_valids_o  (inp_cd_valids),
        .inp_cd_readies_i (inp_cd_readies),
        .inp_cd_data_o    (inp_cd_data),
        .inp_cd_last_o    (inp_cd_last),
        .oup_ac_valid_o   (oup_ac_valid),
        .oup_ac_ready_i   (oup_ac_ready),
        .oup_ac_addr_o    (oup_ac_addr),
        .oup_ac_snoop_o   (oup_ac_snoop),
        .oup_cr_valid_i   (oup_cr_valid),
        .oup_cr_ready_o   (oup_cr_ready),
        .oup_cr_resp_i    (oup_cr_resp),
        .oup_cd_valid_i   (oup_cd_valid),
        .oup_cd_ready_o   (oup_cd_ready),
        .oup_cd_data_i    (oup_cd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    // Index of the single set bit and -1 otherwise
    function automatic int onehot_index(logic [NUM_INP-1:0] v);
        int idx;
        idx = -1;
        if ($countones(v) == 1) begin
            for (int i = 0; i < NUM_INP; i++) begin
                if (v[i]) begin
                    idx = i;
                end
            end
        end
        return idx;
    endfunction

    task automatic protocol_error(string what);
        proto_errors++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic check_idx(string name, inp_idx_t got, inp_idx_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_snoop(string name, snoop_t got, snoop_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(string name, cr_resp_t got, cr_resp_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(string name, cd_data_t got, cd_data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_flag("oup_ac_valid_o", oup_ac_valid, 1'b0);
        if (inp_cr_valids != '0 || inp_cd_valids != '0) begin
            protocol_error("requester valid output high right after reset");
        end
    endtask

    // A handshake sampled at the falling edge completes on the next rising edge
    task automatic observe_ac();
        int owner;
        int fired;
        if (oup_ac_valid && pending == '0) begin
            protocol_error("cache AC valid while no request is pending");
        end
        if (oup_ac_valid && oup_ac_ready) begin
            owner = -1;
            for (int i = 0; i < NUM_INP; i++) begin
                if (pending[i] && inp_ac_addr[i] == oup_ac_addr) begin
                    owner = i;
                end
            end
            if (owner < 0) begin
                protocol_error("cache AC carries the address of no pending request");
            end else if (forwarded[owner]) begin
                protocol_error("request forwarded to the cache twice");
            end else begin
                check_snoop("oup_ac_snoop_o", oup_ac_snoop, inp_ac_snoop[owner]);
                forwarded[owner] = 1'b1;
                fwd_open         = 1'b1;
                fwd_addr         = oup_ac_addr;
                own_idx_q.push_back(inp_idx_t'(owner));
                own_addr_q.push_back(oup_ac_addr);
                cache_q.push_back(oup_ac_addr);
            end
        end
        if (inp_ac_ready != '0) begin
            fired = onehot_index(inp_ac_ready);
            if (fired < 0) begin
                protocol_error("several requesters got ac ready in one cycle");
            end else if (!pending[fired] || !fwd_open) begin
                protocol_error("ac ready for a request that never reached the cache");
            end else begin
                check_addr("oup_ac_addr_o", fwd_addr, inp_ac_addr[fired]);
                if (rr_check) begin
                    check_idx("granted requester", inp_idx_t'(fired),
                              inp_idx_t'((last_grant + 1) % NUM_INP));
                end
                last_grant        = fired;
                grants++;
                pending[fired]   = 1'b0;
                forwarded[fired] = 1'b0;
                fwd_open         = 1'b0;
            end
        end
    endtask

    task automatic observe_cr_cd();
        int fired;
        cr_fired = oup_cr_valid && oup_cr_ready;
        if (inp_cr_valids != '0) begin
            fired = onehot_index(inp_cr_valids);
            if (own_idx_q.size() == 0) begin
                protocol_error("requester cr valid with no snoop outstanding");
            end else if (fired < 0) begin
                protocol_error("cr valid raised toward several requesters");
            end else begin
                check_idx("cr owner", inp_idx_t'(fired), own_idx_q[0]);
                check_resp("inp_cr_resp_o", inp_cr_resp, oup_cr_resp);
            end
        end
        if (((inp_cr_valids & inp_cr_readies) != '0) != cr_fired) begin
            protocol_error("requester CR and cache CR handshakes disagree");
        end else if (cr_fired && own_idx_q.size() != 0) begin
            if (oup_cr_resp[CR_DATA_TRANSFER_BIT]) begin
                cd_idx_q.push_back(own_idx_q[0]);
                cd_addr_q.push_back(own_addr_q[0]);
            end
            void'(own_idx_q.pop_front());
            void'(own_addr_q.pop_front());
            cr_count++;
        end
        cd_fired = oup_cd_valid && oup_cd_ready;
        if (inp_cd_valids != '0) begin
            fired = onehot_index(inp_cd_valids);
            if (cd_idx_q.size() == 0) begin
                protocol_error("CD beat routed without a DataTransfer response");
            end else if (fired < 0) begin
                protocol_error("cd valid raised toward several requesters");
            end else begin
                check_idx("cd owner", inp_idx_t'(fired), cd_idx_q[0]);
                check_data("inp_cd_data_o", inp_cd_data,
                           cd_data_t'(cd_addr_q[0] + addr_t'(cd_beat)));
                check_flag("inp_cd_last_o", inp_cd_last, cd_beat == CD_BEATS - 1);
            end
        end
        if (((inp_cd_valids & inp_cd_readies) != '0) != cd_fired) begin
            protocol_error("requester CD and cache CD handshakes disagree");
        end else if (cd_fired && cd_idx_q.size() != 0) begin
            cd_beat++;
            if (cd_beat == CD_BEATS) begin
                cd_beat = 0;
                void'(cd_idx_q.pop_front());
                void'(cd_addr_q.pop_front());
            end
        end
    endtask

    task automatic drive_requesters();
        for (int i = 0; i < NUM_INP; i++) begin
            if (!pending[i]) begin
                inp_ac_valid[i] = 1'b0;
                if (issued < NUM_SNOOPS && (rr_check || rand_below(4) == 0)) begin
                    // The issue count keeps every address unique
                    inp_ac_addr[i]  = addr_t'({issued[19:0], 4'(i), 8'h00});
                    inp_ac_snoop[i] = snoop_t'(lcg_next() >> 12);
                    inp_ac_valid[i] = 1'b1;
                    pending[i]      = 1'b1;
                    issued++;
                end
            end
        end
        inp_cr_readies = NUM_INP'(lcg_next() >> 9);
        inp_cd_readies = NUM_INP'(lcg_next() >> 13);
        oup_ac_ready   = (rand_below(3) != 0);
    endtask

    // Answers snoops in order with the CR and then any CD burst
    task automatic drive_cache();
        case (cache_state)
            C_IDLE: begin
                if (cache_q.size() != 0) begin
                    cache_addr  = cache_q.pop_front();
                    cache_delay = rand_below(4);
                    cache_state = C_WAIT;
                end
            end
            C_WAIT: begin
                if (cache_delay == 0) begin
                    oup_cr_valid = 1'b1;
                    oup_cr_resp  = cr_resp_t'(lcg_next() >> 11);
                    cache_state  = C_CR;
                end else begin
                    cache_delay--;
                end
            end
            C_CR: begin
                if (cr_fired) begin
                    oup_cr_valid = 1'b0;
                    cache_beat   = 0;
                    cache_state  = oup_cr_resp[CR_DATA_TRANSFER_BIT] ? C_CD : C_IDLE;
                end
            end
            default: begin
                if (cd_fired) begin
                    oup_cd_valid = 1'b0;
                    cache_beat++;
                end
                if (cache_beat == CD_BEATS) begin
                    cache_state = C_IDLE;
                end else if (!oup_cd_valid && rand_below(3) != 0) begin
                    oup_cd_valid = 1'b1;
                    oup_cd_data  = cd_data_t'(cache_addr + addr_t'(cache_beat));
                end
            end
        endcase
    endtask

    task automatic step();
        @(posedge clk);
        #5;
        drive_requesters();
        drive_cache();
        @(negedge clk);
        observe_ac();
        observe_cr_cd();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d value, %0d protocol, %0d snoops issued, %0d responses",
                     value_errors, proto_errors, issued, cr_count);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed           = 32'h827b;
        last_grant     = -1;
        arst_n         = 1'b0;
        inp_ac_valid   = '0;
        inp_ac_addr    = '0;
        inp_ac_snoop   = '0;
        inp_cr_readies = '0;
        inp_cd_readies = '0;
        oup_ac_ready   = 1'b0;
        oup_cr_valid   = 1'b0;
        oup_cr_resp    = '0;
        oup_cd_valid   = 1'b0;
        oup_cd_data    = '0;
        cache_state    = C_IDLE;
        repeat (8) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check_idle();

        // All requesters stay valid at first so that grants must rotate
        rr_check = 1'b1;
        while (!(issued == NUM_SNOOPS && cr_count == issued && pending == '0 &&
                 cache_state == C_IDLE && cache_q.size() == 0 && cd_idx_q.size() == 0)) begin
            step();
            if (rr_check && grants >= RR_GRANTS) begin
                rr_check = 1'b0;
            end
        end
        // Quiet tail catches stray responses or beats
        repeat (10) step();
        if (own_idx_q.size() != 0 || cr_count != issued || grants != issued) begin
            protocol_error("snoops and responses do not pair up one to one");
        end

        $display("errors: %0d value, %0d protocol, %0d snoops issued, %0d responses",
                 value_errors, proto_errors, issued, cr_count);
        if (value_errors + proto_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/snoop_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_subsystem_top import snoop_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  logic   [NUM_INP-1:0]   inp_ac_valid_i,
    output logic   [NUM_INP-1:0]   inp_ac_ready_o,
    input  addr_t  [NUM_INP-1:0]   inp_ac_addr_i,
    input  snoop_t [NUM_INP-1:0]   inp_ac_snoop_i,

    output logic   [NUM_INP-1:0]   inp_cr_valids_o,
    input  logic   [NUM_INP-1:0]   inp_cr_readies_i,
    output cr_resp_t               inp_cr_resp_o,

    output logic   [NUM_INP-1:0]   inp_cd_valids_o,
    input  logic   [NUM_INP-1:0]   inp_cd_readies_i,
    output cd_data_t               inp_cd_data_o,
    output logic                   inp_cd_last_o,

    output logic                   oup_ac_valid_o,
    input  logic                   oup_ac_ready_i,
    output addr_t                  oup_ac_addr_o,
    output snoop_t                 oup_ac_snoop_o,

    input  logic                   oup_cr_valid_i,
    output logic                   oup_cr_ready_o,
    input  cr_resp_t               oup_cr_resp_i,

    input  logic                   oup_cd_valid_i,
    output logic                   oup_cd_ready_o,
    input  cd_data_t               oup_cd_data_i
);
    snoop_ac_if ac_if ();

    snoop_arbiter i_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (inp_ac_valid_i),
        .req_ready_o (inp_ac_ready_o),
        .req_addr_i  (inp_ac_addr_i),
        .req_snoop_i (inp_ac_snoop_i),
        .ac          (ac_if)
    );

    snoop_port i_port (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .ac               (ac_if),
        .oup_ac_valid_o   (oup_ac_valid_o),
        .oup_ac_ready_i   (oup_ac_ready_i),
        .oup_ac_addr_o    (oup_ac_addr_o),
        .oup_ac_snoop_o   (oup_ac_snoop_o),
        .oup_cr_valid_i   (oup_cr_valid_i),
        .oup_cr_ready_o   (oup_cr_ready_o),
        .oup_cr_resp_i    (oup_cr_resp_i),
        .oup_cd_valid_i   (oup_cd_valid_i),
        .oup_cd_ready_o   (oup_cd_ready_o),
        .oup_cd_data_i    (oup_cd_data_i),
        .inp_cr_valids_o  (inp_cr_valids_o),
        .inp_cr_readies_i (inp_cr_readies_i),
        .inp_cr_resp_o    (inp_cr_resp_o),
        .inp_cd_valids_o  (inp_cd_valids_o),
        .inp_cd_readies_i (inp_cd_readies_i),
        .inp_cd_data_o    (inp_cd_data_o),
        .inp_cd_last_o    (inp_cd_last_o)
    );

endmodule

`default_nettype wire

// ==== source/snoop_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_port import snoop_pkg::*; (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    snoop_ac_if.port             ac,

    output logic                 oup_ac_valid_o,
    input  logic                 oup_ac_ready_i,
    output addr_t                oup_ac_addr_o,
    output snoop_t               oup_ac_snoop_o,

    input  logic                 oup_cr_valid_i,
    output logic                 oup_cr_ready_o,
    input  cr_resp_t             oup_cr_resp_i,

    input  logic                 oup_cd_valid_i,
    output logic                 oup_cd_ready_o,
    input  cd_data_t             oup_cd_data_i,

    output logic   [NUM_INP-1:0] inp_cr_valids_o,
    input  logic   [NUM_INP-1:0] inp_cr_readies_i,
    output cr_resp_t             inp_cr_resp_o,

    output logic   [NUM_INP-1:0] inp_cd_valids_o,
    input  logic   [NUM_INP-1:0] inp_cd_readies_i,
    output cd_data_t             inp_cd_data_o,
    output logic                 inp_cd_last_o
);
    // Bit 0 is the cache side, bit 1 the index FIFO
    logic [1:0] taken_q;
    logic [1:0] side_done;

    logic     fifo_push_valid, fifo_push_ready;
    logic     head_valid;
    inp_idx_t head_idx;

    logic cr_dt, cr_path_ok, cr_valid, cr_fire;

    logic     lock_valid_q;
    inp_idx_t lock_idx_q;
    logic     cd_fire, cd_last;

    // Payload is broadcast and only the valids are steered
    assign oup_ac_addr_o  = ac.addr;
    assign oup_ac_snoop_o = ac.snoop;
    assign inp_cr_resp_o  = oup_cr_resp_i;
    assign inp_cd_data_o  = oup_cd_data_i;
    assign inp_cd_last_o  = cd_last;

    // The cache only sees a snoop once its index has a FIFO slot
    assign fifo_push_valid = ac.valid && !taken_q[1];
    assign oup_ac_valid_o  = ac.valid && !taken_q[0] && (fifo_push_ready || taken_q[1]);
    assign side_done[0]    = taken_q[0] || (oup_ac_valid_o && oup_ac_ready_i);
    assign side_done[1]    = taken_q[1] || (fifo_push_valid && fifo_push_ready);
    assign ac.ready        = &side_done;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taken_q <= '0;
        end else if (ac.valid) begin
            if (ac.ready) begin
                taken_q <= '0;
            end else begin
                taken_q <= side_done;
            end
        end
    end

    snoop_idx_fifo i_idx_fifo (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_valid_i (fifo_push_valid),
        .push_ready_o (fifo_push_ready),
        .push_idx_i   (ac.idx),
        .pop_valid_o  (head_valid),
        .pop_ready_i  (cr_fire),
        .pop_idx_o    (head_idx)
    );

    // CR to the owner of the oldest snoop
    assign cr_dt      = oup_cr_resp_i[CR_DATA_TRANSFER_BIT];
    assign cr_path_ok = !cr_dt || !lock_valid_q;
    assign cr_valid   = oup_cr_valid_i && head_valid && cr_path_ok;
    assign cr_fire    = cr_valid && inp_cr_readies_i[head_idx];

    assign oup_cr_ready_o = head_valid && cr_path_ok && inp_cr_readies_i[head_idx];

    always_comb begin
        inp_cr_valids_o           = '0;
        inp_cr_valids_o[head_idx] = cr_valid;
    end

    // CD owner is held for the whole burst
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lock_valid_q <= 1'b0;
        end else if (cr_fire && cr_dt) begin
            lock_valid_q <= 1'b1;
        end else if (cd_fire && cd_last) begin
            lock_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cr_fire && cr_dt) begin
            lock_idx_q <= head_idx;
        end
    end

    assign oup_cd_ready_o = lock_valid_q && inp_cd_readies_i[lock_idx_q];
    assign cd_fire        = oup_cd_valid_i && oup_cd_ready_o;

    always_comb begin
        inp_cd_valids_o             = '0;
        inp_cd_valids_o[lock_idx_q] = oup_cd_valid_i && lock_valid_q;
    end

    cd_beat_counter i_beat_cnt (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .beat_i   (cd_fire),
        .last_o   (cd_last)
    );

    // A data response is never accepted while a burst still holds the lock
    a_cr_lock : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        cr_fire && cr_dt |-> !lock_valid_q
    );

endmodule

`default_nettype wire

// ==== source/cd_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cd_beat_counter import snoop_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,

    // One pulse per accepted CD beat
    input  logic beat_i,
    output logic last_o
);
    beat_cnt_t cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (beat_i) begin
            if (last_o) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // High while waiting for the beat that completes the burst
    assign last_o = (cnt_q == beat_cnt_t'(CD_BEATS - 1));

endmodule

`default_nettype wire

// ==== source/snoop_idx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_idx_fifo import snoop_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  inp_idx_t push_idx_i,

    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output inp_idx_t pop_idx_o
);
    localparam int PTR_W = (IDX_FIFO_DEPTH > 1) ? $clog2(IDX_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(IDX_FIFO_DEPTH + 1);

    inp_idx_t mem_q [IDX_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;

    logic push_fire;
    logic pop_fire;

    assign push_ready_o = (cnt_q != CNT_W'(IDX_FIFO_DEPTH));
    assign pop_valid_o  = (cnt_q != '0);
    assign pop_idx_o    = mem_q[rd_ptr_q];

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_fire) begin
                if (wr_ptr_q == PTR_W'(IDX_FIFO_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop_fire) begin
                if (rd_ptr_q == PTR_W'(IDX_FIFO_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            if (push_fire && !pop_fire) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop_fire && !push_fire) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem_q[wr_ptr_q] <= push_idx_i;
        end
    end

    // Full FIFO stalls the push, and the pusher keeps its index
    a_no_push_full : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_idx_i)
    );

    // The CR side only asks for a pop when a snoop is outstanding
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pop_ready_i |-> pop_valid_o
    );

endmodule

`default_nettype wire

// ==== source/snoop_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_arbiter import snoop_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  logic   [NUM_INP-1:0]   req_valid_i,
    output logic   [NUM_INP-1:0]   req_ready_o,
    input  addr_t  [NUM_INP-1:0]   req_addr_i,
    input  snoop_t [NUM_INP-1:0]   req_snoop_i,

    snoop_ac_if.arb                ac
);
    arb_state_t state_q, state_d;
    inp_idx_t   ptr_q;

    inp_idx_t grant_idx_q;
    addr_t    grant_addr_q;
    snoop_t   grant_snoop_q;

    inp_idx_t pick_idx;
    logic     pick_found;
    logic     ac_fire;

    // First valid requester at or after the round-robin pointer
    always_comb begin : pick
        int cand;
        pick_idx   = ptr_q;
        pick_found = 1'b0;
        for (int i = 0; i < NUM_INP; i++) begin
            cand = (int'(ptr_q) + i) % NUM_INP;
            if (!pick_found && req_valid_i[cand]) begin
                pick_found = 1'b1;
                pick_idx   = inp_idx_t'(cand);
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (pick_found) begin
                    state_d = ARB_GRANT;
                end
            end
            ARB_GRANT: begin
                if (ac_fire) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (ac_fire) begin
                // Skip past the requester just served
                if (grant_idx_q == inp_idx_t'(NUM_INP - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= grant_idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ARB_IDLE && pick_found) begin
            grant_idx_q   <= pick_idx;
            grant_addr_q  <= req_addr_i[pick_idx];
            grant_snoop_q <= req_snoop_i[pick_idx];
        end
    end

    assign ac.valid = (state_q == ARB_GRANT);
    assign ac.idx   = grant_idx_q;
    assign ac.addr  = grant_addr_q;
    assign ac.snoop = grant_snoop_q;
    assign ac_fire  = ac.valid && ac.ready;

    always_comb begin
        req_ready_o              = '0;
        req_ready_o[grant_idx_q] = ac_fire;
    end

    // Granted request holds until the port takes it
    a_ac_stable : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ac.valid && !ac.ready |=>
            ac.valid && $stable(ac.addr) && $stable(ac.snoop) && $stable(ac.idx)
    );

endmodule

`default_nettype wire

// ==== source/snoop_ac_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Arbitrated AC request, arbiter to snoop port
interface snoop_ac_if import snoop_pkg::*; ();

    logic     valid;
    logic     ready;
    addr_t    addr;
    snoop_t   snoop;
    // Requester that owns this snoop
    inp_idx_t idx;

    modport arb (
        output valid,
        output addr,
        output snoop,
        output idx,
        input  ready
    );

    modport port (
        input  valid,
        input  addr,
        input  snoop,
        input  idx,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/snoop_pkg.sv ====
`default_nettype none

package snoop_pkg;

    // Number of requesters sharing the snooped cache
    localparam int NUM_INP = 4;

    // Fixed CD burst length in beats
    localparam int CD_BEATS = 4;

    // Snoops that may be outstanding at the cache
    localparam int IDX_FIFO_DEPTH = 2;

    // Position of the DataTransfer flag inside the CR response
    localparam int CR_DATA_TRANSFER_BIT = 0;

    typedef logic [31:0] addr_t;
    typedef logic [3:0]  snoop_t;
    typedef logic [4:0]  cr_resp_t;
    typedef logic [63:0] cd_data_t;

    typedef logic [$clog2(NUM_INP)-1:0]  inp_idx_t;
    typedef logic [$clog2(CD_BEATS)-1:0] beat_cnt_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_GRANT
    } arb_state_t;

endpackage

`default_nettype wire
